// File: verilog/backend_consts.svh
// shared width, reset pc, data memory depth and latency macros for the back end and its testbench
`ifndef BACKEND_CONSTS_SVH
`define BACKEND_CONSTS_SVH

// data and address width
`define XLEN 64

// pc held while in reset
// an issue carrying this pc is the fetch bubble, never accepted
`define PC_START_RESET 64'h0000_0000_8000_0000

// data memory depth, in 64-bit words
`define DMEM_WORDS 256

// cycles from req to ack
`define MEM_LAT 3

`endif

// File: verilog/core_pkg.sv
// instruction-level types shared by the sequencer, lsu, register file and commit unit
`include "backend_consts.svh"

package core_pkg;

  typedef logic [`XLEN-1:0] xword_t;  // one machine word

  // per-instruction progress, 3 bits
  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    MEMREAD  = 3'd1,
    MEMWRITE = 3'd2,
    WB       = 3'd3,
    CMT      = 3'd4
  } inst_state_e;

  typedef enum logic [1:0] {
    LOAD  = 2'd0,  // mem read then wb
    STORE = 2'd1,  // mem write then commit
    ALU   = 2'd2   // wb only
  } op_kind_e;

  typedef enum logic [1:0] {
    BYTE  = 2'd0,
    HALF  = 2'd1,
    WORD  = 2'd2,
    DWORD = 2'd3
  } acc_size_e;

  // issued instruction, held for the whole walk through the states
  typedef struct packed {
    xword_t    pc;
    op_kind_e  kind;
    acc_size_e size;
    logic      is_unsigned;  // zero-extend on load
    logic [4:0] rd;
    xword_t    addr;         // byte address, loads and stores
    xword_t    wdata;        // store data, right aligned
    xword_t    result;       // alu result for wb
  } inst_t;

endpackage

// File: verilog/mem_pkg.sv
// memory-side types for the data memory interface, lsu and ram
`include "backend_consts.svh"

package mem_pkg;

  localparam int LANES = `XLEN / 8;  // byte lanes per word

  // one memory word, seen whole or lane by lane
  // lane view used for store placement and load extraction
  typedef union packed {
    logic [`XLEN-1:0]         dword;
    logic [LANES-1:0][7:0]    lanes;  // lanes[0] is the lowest address
  } mem_word_u;

  // one bit per byte lane
  typedef logic [LANES-1:0] byte_strobe_t;

endpackage

// File: verilog/dmem_if.sv
// data memory request/response bundle between the lsu and the ram
`timescale 1ns/1ps
`include "backend_consts.svh"

interface dmem_if;
  import mem_pkg::*;

  logic               req;    // one-cycle strobe
  logic               we;     // 1 = write, valid with req
  logic [`XLEN-1:0]   addr;   // byte address
  mem_word_u          wdata;  // already lane placed
  byte_strobe_t       wstrb;
  logic               ack;    // MEM_LAT cycles after req
  mem_word_u          rdata;  // valid with ack

  modport lsu (
    output req, we, addr, wdata, wstrb,
    input  ack, rdata
  );

  modport mem (
    input  req, we, addr, wdata, wstrb,
    output ack, rdata
  );

endinterface

// File: verilog/inst_seq.sv
// per-instruction state machine, accepts one issue in IDLE and latches its record
`timescale 1ns/1ps
`include "backend_consts.svh"

module inst_seq (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  issue,
  input  core_pkg::xword_t      issue_pc,
  input  core_pkg::op_kind_e    issue_kind,
  input  core_pkg::acc_size_e   issue_size,
  input  logic                  issue_unsigned,
  input  logic [4:0]            issue_rd,
  input  core_pkg::xword_t      issue_addr,
  input  core_pkg::xword_t      issue_wdata,
  input  core_pkg::xword_t      issue_result,
  input  logic                  mem_done,
  output core_pkg::inst_state_e state,
  output core_pkg::inst_t       cur
);
  import core_pkg::*;

  inst_state_e state_q;
  inst_state_e state_d;
  logic        accept;

  // fetch bubble still carries the reset pc, so it is not a real instruction
  assign accept = issue && (issue_pc != `PC_START_RESET) && (state_q == IDLE);

  always_comb begin
    state_d = state_q;  // hold by default
    unique case (state_q)
      IDLE: begin
        if (accept) begin
          unique case (issue_kind)
            LOAD:    state_d = MEMREAD;
            STORE:   state_d = MEMWRITE;
            default: state_d = WB;  // alu
          endcase
        end
      end
      MEMREAD:  if (mem_done) state_d = WB;
      MEMWRITE: if (mem_done) state_d = CMT;
      WB:       state_d = CMT;   // one cycle
      CMT:      state_d = IDLE;  // one cycle
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) state_q <= IDLE;
    else     state_q <= state_d;
  end

  // instruction record, only loaded on accept
  always_ff @(posedge clk) begin
    if (accept) begin
      cur.pc          <= issue_pc;
      cur.kind        <= issue_kind;
      cur.size        <= issue_size;
      cur.is_unsigned <= issue_unsigned;
      cur.rd          <= issue_rd;
      cur.addr        <= issue_addr;
      cur.wdata       <= issue_wdata;
      cur.result      <= issue_result;
    end
  end

  assign state = state_q;

endmodule

// File: verilog/lsu.sv
// load-store unit, one data memory request per memory state plus lane placement and extension
`timescale 1ns/1ps

module lsu (
  input  logic                  clk,
  input  logic                  rst,
  input  core_pkg::inst_state_e state,
  input  core_pkg::inst_t       cur,
  dmem_if.lsu                   mem,
  output logic                  mem_done,
  output core_pkg::xword_t      load_data
);
  import core_pkg::*;
  import mem_pkg::*;

  logic         mem_state;
  logic         sent;      // request already out for this instruction
  logic [2:0]   off;       // byte offset within the word
  mem_word_u    st_src;
  mem_word_u    st_lane;
  byte_strobe_t st_mask;
  mem_word_u    ld_raw;
  mem_word_u    ld_shift;
  xword_t       ld_ext;

  assign mem_state = (state == MEMREAD) || (state == MEMWRITE);
  assign off       = cur.addr[2:0];

  // req only in the first cycle of a memory state
  assign mem.req   = mem_state && !sent;
  assign mem.we    = (state == MEMWRITE);
  assign mem.addr  = cur.addr;
  assign mem.wdata = st_lane;
  assign mem.wstrb = st_mask;

  always_ff @(posedge clk) begin
    if (rst)            sent <= 1'b0;
    else if (!mem_state) sent <= 1'b0;  // rearm once out of mem states
    else if (mem.req)   sent <= 1'b1;
  end

  // store: rotate low bytes up to the addressed lane
  always_comb begin
    st_src.dword = cur.wdata;
    for (int i = 0; i < LANES; i++) begin
      st_lane.lanes[i] = st_src.lanes[3'(i - off)];
    end
  end

  always_comb begin
    unique case (cur.size)
      BYTE:    st_mask = byte_strobe_t'(8'h01 << off);
      HALF:    st_mask = byte_strobe_t'(8'h03 << off);
      WORD:    st_mask = byte_strobe_t'(8'h0f << off);
      default: st_mask = 8'hff;  // dword, offset is 0
    endcase
  end

  // load: rotate addressed lane down to lane 0, then extend
  always_comb begin
    ld_raw = mem.rdata;
    for (int i = 0; i < LANES; i++) begin
      ld_shift.lanes[i] = ld_raw.lanes[3'(i + off)];
    end
    unique case (cur.size)
      BYTE:
        ld_ext = {{56{~cur.is_unsigned & ld_shift.lanes[0][7]}}, ld_shift.lanes[0]};
      HALF:
        ld_ext = {{48{~cur.is_unsigned & ld_shift.lanes[1][7]}}, ld_shift.lanes[1:0]};
      WORD:
        ld_ext = {{32{~cur.is_unsigned & ld_shift.lanes[3][7]}}, ld_shift.lanes[3:0]};
      default:
        ld_ext = ld_shift.dword;
    endcase
  end

  // done strobe one edge after ack, together with the load result
  always_ff @(posedge clk) begin
    if (rst) mem_done <= 1'b0;
    else     mem_done <= mem.ack;
  end

  always_ff @(posedge clk) begin
    if (mem.ack && state == MEMREAD) load_data <= ld_ext;  // held until next load
  end

endmodule

// File: verilog/data_mem.sv
// word-addressed data ram with byte strobes, acknowledges each request after a fixed latency
`timescale 1ns/1ps
`include "backend_consts.svh"

module data_mem (
  input logic clk,
  input logic rst,
  dmem_if.mem mem
);
  import mem_pkg::*;

  localparam int AW  = $clog2(`DMEM_WORDS);
  localparam int LAT = `MEM_LAT;
  localparam int CW  = $clog2(LAT + 1);

  mem_word_u      ram [`DMEM_WORDS] = '{default: '0};  // starts cleared
  mem_word_u      rd_q;
  logic [AW-1:0]  idx;
  logic [CW-1:0]  cnt;   // cycles left until ack
  logic           ack_q;

  // low 3 bits pick the lane, bits above the depth dropped
  assign idx = mem.addr[AW+2:3];

  always_ff @(posedge clk) begin
    if (mem.req) begin
      rd_q <= ram[idx];  // old contents, loads only look at this
      if (mem.we) begin
        for (int b = 0; b < LANES; b++) begin
          if (mem.wstrb[b]) ram[idx].lanes[b] <= mem.wdata.lanes[b];
        end
      end
    end
  end

  // latency countdown
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt   <= '0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= (mem.req && LAT == 1) || (cnt == CW'(1));
      if (mem.req)        cnt <= CW'(LAT - 1);
      else if (cnt != '0) cnt <= cnt - 1'b1;
    end
  end

  assign mem.ack   = ack_q;
  assign mem.rdata = rd_q;

endmodule

// File: verilog/reg_file.sv
// 32 x 64 integer register file, written in WB, with a combinational debug read port
`timescale 1ns/1ps

module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  core_pkg::inst_state_e state,
  input  core_pkg::inst_t       cur,
  input  core_pkg::xword_t      load_data,
  input  logic [4:0]            dbg_rs,
  output core_pkg::xword_t      dbg_rdata
);
  import core_pkg::*;

  xword_t regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < 32; r++) begin
        regs[r] <= '0;
      end
    end else if (state == WB && cur.rd != 5'd0) begin  // x0 writes dropped
      regs[cur.rd] <= (cur.kind == LOAD) ? load_data : cur.result;
    end
  end

  // combinational debug read
  assign dbg_rdata = regs[dbg_rs];

endmodule

// File: verilog/commit_unit.sv
// retire strobe, retired pc and instret counter, all updated at the end of CMT
`timescale 1ns/1ps

module commit_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  core_pkg::inst_state_e state,
  input  core_pkg::inst_t       cur,
  output logic                  retire,
  output core_pkg::xword_t      retire_pc,
  output logic [63:0]           instret
);
  import core_pkg::*;

  logic in_cmt;

  assign in_cmt = (state == CMT);

  always_ff @(posedge clk) begin
    if (rst) begin
      retire  <= 1'b0;
      instret <= '0;
    end else begin
      retire <= in_cmt;  // pulses with the return to IDLE
      if (in_cmt) instret <= instret + 64'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (in_cmt) retire_pc <= cur.pc;
  end

endmodule

// File: verilog/backend_top.sv
// back-end top level, wires sequencer, lsu, data ram, register file and commit unit
`timescale 1ns/1ps

module backend_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                issue,           // one-cycle strobe
  input  core_pkg::xword_t    issue_pc,
  input  core_pkg::op_kind_e  issue_kind,
  input  core_pkg::acc_size_e issue_size,
  input  logic                issue_unsigned,
  input  logic [4:0]          issue_rd,
  input  core_pkg::xword_t    issue_addr,
  input  core_pkg::xword_t    issue_wdata,
  input  core_pkg::xword_t    issue_result,
  input  logic [4:0]          dbg_rs,
  output logic                busy,            // upstream holds off while high
  output logic                retire,
  output core_pkg::xword_t    retire_pc,
  output logic [63:0]         instret,
  output core_pkg::xword_t    dbg_rdata
);
  import core_pkg::*;

  inst_state_e state;
  inst_t       cur;
  logic        mem_done;
  xword_t      load_data;

  dmem_if u_dmem_if ();

  inst_seq u_inst_seq (
    .clk            (clk),
    .rst            (rst),
    .issue          (issue),
    .issue_pc       (issue_pc),
    .issue_kind     (issue_kind),
    .issue_size     (issue_size),
    .issue_unsigned (issue_unsigned),
    .issue_rd       (issue_rd),
    .issue_addr     (issue_addr),
    .issue_wdata    (issue_wdata),
    .issue_result   (issue_result),
    .mem_done       (mem_done),
    .state          (state),
    .cur            (cur)
  );

  lsu u_lsu (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .cur       (cur),
    .mem       (u_dmem_if.lsu),
    .mem_done  (mem_done),
    .load_data (load_data)
  );

  data_mem u_data_mem (
    .clk (clk),
    .rst (rst),
    .mem (u_dmem_if.mem)
  );

  reg_file u_reg_file (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .cur       (cur),
    .load_data (load_data),
    .dbg_rs    (dbg_rs),
    .dbg_rdata (dbg_rdata)
  );

  commit_unit u_commit_unit (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .cur       (cur),
    .retire    (retire),
    .retire_pc (retire_pc),
    .instret   (instret)
  );

  assign busy = (state != IDLE);  // any instruction in flight

endmodule

// File: dv/backend_checker.sv
// protocol assertions on the data memory bus and retire, bound into backend_top by the testbench
`timescale 1ns/1ps
`include "backend_consts.svh"

module backend_checker (
  input logic                  clk,
  input logic                  rst,
  input core_pkg::inst_state_e state,
  input core_pkg::acc_size_e   size,
  input logic                  req,
  input logic                  ack,
  input core_pkg::xword_t      addr,
  input logic                  retire
);
  import core_pkg::*;

  int         fail_count = 0;  // polled by the testbench at the end
  logic [2:0] align_mask;

  assign align_mask = 3'((4'd1 << size) - 4'd1);  // low address bits that must be 0

  // one request outstanding at most
  a_single_req: assert property (@(posedge clk) disable iff (rst)
    req |=> (!req) [*`MEM_LAT])
    else begin
      $error("req raised again while a request was outstanding");
      fail_count++;
    end

  a_ack_lat: assert property (@(posedge clk) disable iff (rst)
    req |-> ##`MEM_LAT ack)
    else begin
      $error("ack did not follow req after the memory latency");
      fail_count++;
    end

  a_retire_cmt: assert property (@(posedge clk) disable iff (rst)
    retire |-> ($past(state) == CMT))
    else begin
      $error("retire without a CMT state the cycle before");
      fail_count++;
    end

  a_aligned: assert property (@(posedge clk) disable iff (rst)
    req |-> ((addr[2:0] & align_mask) == 3'd0))
    else begin
      $error("misaligned data memory access");
      fail_count++;
    end

endmodule

// File: dv/backend_tb.sv
// self-checking testbench for the back end, runs a table of issues and then a seeded random burst
`timescale 1ns/1ps
`include "backend_consts.svh"

module backend_tb;
  import core_pkg::*;

  localparam int NROWS = 20;
  localparam int NRAND = 12;
  localparam int TMO   = 40;  // cycles allowed per retire

  // shadow rows are issued while the row before them is still in flight
  typedef enum {NORMAL, BUBBLE, SHADOW} row_mode_e;

  typedef struct {
    xword_t     pc;
    op_kind_e   kind;
    acc_size_e  size;
    logic       uns;
    logic [4:0] rd;
    xword_t     addr;
    xword_t     data;  // store data or alu result, by kind
    row_mode_e  mode;
  } row_t;

  logic        clk = 1'b0;
  logic        rst;
  logic        issue;
  xword_t      issue_pc;
  op_kind_e    issue_kind;
  acc_size_e   issue_size;
  logic        issue_unsigned;
  logic [4:0]  issue_rd;
  xword_t      issue_addr;
  xword_t      issue_wdata;
  xword_t      issue_result;
  logic [4:0]  dbg_rs;
  logic        busy;
  logic        retire;
  xword_t      retire_pc;
  logic [63:0] instret;
  xword_t      dbg_rdata;

  // reference model, byte addressed memory and the register file
  xword_t      mdl_regs [32] = '{default: '0};
  logic [7:0]  mdl_mem [`DMEM_WORDS * 8] = '{default: 8'h00};
  int          accepted = 0;

  row_t tbl [NROWS] = '{
    '{64'h1000, ALU,   DWORD, 0, 1,  64'h0,   64'h0123_4567_89ab_cdef, NORMAL},
    '{64'h1004, ALU,   DWORD, 0, 2,  64'h0,   64'hfedc_ba98_7654_3210, NORMAL},
    '{64'h1008, ALU,   DWORD, 0, 0,  64'h0,   64'hffff_ffff_ffff_ffff, NORMAL},  // x0
    '{64'h100c, STORE, DWORD, 0, 0,  64'h40,  64'h1111_2222_3333_4444, NORMAL},
    '{64'h1010, STORE, BYTE,  0, 0,  64'h43,  64'hffff_ffff_ffff_ffa5, NORMAL},
    '{64'h1014, STORE, HALF,  0, 0,  64'h46,  64'hdead_beef_cafe_8877, NORMAL},
    '{64'h1018, LOAD,  DWORD, 0, 3,  64'h40,  64'h0,                   NORMAL},  // merged
    '{64'h101c, STORE, WORD,  0, 0,  64'h44,  64'h0bad_f00d_9abc_def0, NORMAL},
    '{64'h1020, LOAD,  DWORD, 0, 4,  64'h40,  64'h0,                   NORMAL},
    '{64'h1024, STORE, DWORD, 0, 0,  64'h80,  64'hf0e1_d2c3_b4a5_9687, NORMAL},
    '{64'h1028, LOAD,  BYTE,  0, 5,  64'h81,  64'h0,                   NORMAL},  // lb
    '{64'h102c, LOAD,  BYTE,  1, 6,  64'h82,  64'h0,                   NORMAL},  // lbu
    '{64'h1030, LOAD,  HALF,  0, 7,  64'h82,  64'h0,                   NORMAL},  // lh
    '{64'h1034, LOAD,  HALF,  1, 8,  64'h86,  64'h0,                   NORMAL},  // lhu
    '{64'h1038, LOAD,  WORD,  0, 9,  64'h84,  64'h0,                   NORMAL},  // lw
    '{64'h103c, LOAD,  WORD,  1, 10, 64'h80,  64'h0,                   NORMAL},  // lwu
    '{`PC_START_RESET, ALU, DWORD, 0, 11, 64'h0, 64'h7777_7777_7777_7777, BUBBLE},
    '{64'h1040, LOAD,  DWORD, 0, 12, 64'h80,  64'h0,                   NORMAL},
    '{64'h1044, ALU,   DWORD, 0, 12, 64'h0,   64'h5a5a_5a5a_5a5a_5a5a, SHADOW},
    '{64'h1048, LOAD,  DWORD, 0, 13, 64'h840, 64'h0,                   NORMAL}   // wraps to 0x40
  };

  backend_top u_backend_top (.*);

  bind backend_top backend_checker u_checker (
    .clk    (clk),
    .rst    (rst),
    .state  (state),
    .size   (cur.size),
    .req    (u_dmem_if.req),
    .ack    (u_dmem_if.ack),
    .addr   (u_dmem_if.addr),
    .retire (retire)
  );

  always #20 clk = ~clk;  // 40 ns period

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  // watch the bound protocol checker
  always @(posedge clk) begin
    if (u_backend_top.u_checker.fail_count != 0)
      abort_run("protocol checker flagged an assertion failure");
  end

  task automatic check_word(xword_t got, xword_t exp, string what);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                          $time, what, got, exp));
  endtask

  task automatic check_state(inst_state_e got, inst_state_e exp, string what);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED at %0t: %s is %s, expected %s",
                          $time, what, got.name(), exp.name()));
  endtask

  task automatic check_count(logic [63:0] got, logic [63:0] exp, string what);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d",
                          $time, what, got, exp));
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp)
      abort_run($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                          $time, what, got, exp));
  endtask

  function automatic inst_state_e entry_state(op_kind_e k);
    case (k)
      LOAD:    return MEMREAD;
      STORE:   return MEMWRITE;
      default: return WB;
    endcase
  endfunction

  // bytes land at addr..addr+n-1, bits above the depth wrap
  task automatic model_store(xword_t addr, acc_size_e sz, xword_t val);
    int base;
    base = int'(addr % (`DMEM_WORDS * 8));
    for (int b = 0; b < (1 << sz); b++) mdl_mem[base + b] = val[8*b +: 8];
  endtask

  function automatic xword_t model_load(xword_t addr, acc_size_e sz, logic uns);
    int     base;
    int     n;
    xword_t v;
    base = int'(addr % (`DMEM_WORDS * 8));
    n    = 1 << sz;
    v    = '0;
    for (int b = 0; b < n; b++) v[8*b +: 8] = mdl_mem[base + b];
    if (!uns && v[8*n-1])
      for (int b = n; b < 8; b++) v[8*b +: 8] = 8'hff;  // sign fill
    return v;
  endfunction

  task automatic model_apply(row_t r);
    case (r.kind)
      STORE:   model_store(r.addr, r.size, r.data);
      LOAD:    if (r.rd != 0) mdl_regs[r.rd] = model_load(r.addr, r.size, r.uns);
      default: if (r.rd != 0) mdl_regs[r.rd] = r.data;
    endcase
  endtask

  function automatic row_t random_op(int idx);
    row_t r;
    int   word;
    r.kind = op_kind_e'($urandom_range(0, 2));
    r.size = acc_size_e'($urandom_range(0, 3));
    word   = $urandom_range(8, 31);
    r.pc   = 64'h2000 + 64'(idx) * 4;
    r.uns  = 1'($urandom_range(0, 1));
    r.rd   = 5'($urandom_range(0, 31));
    r.addr = 64'(word * 8 + (($urandom_range(0, 7) >> r.size) << r.size));  // aligned
    r.data = {$urandom, $urandom};
    r.mode = NORMAL;
    return r;
  endfunction

  task automatic drive_issue(row_t r);
    @(posedge clk);
    issue          <= 1'b1;
    issue_pc       <= r.pc;
    issue_kind     <= r.kind;
    issue_size     <= r.size;
    issue_unsigned <= r.uns;
    issue_rd       <= r.rd;
    issue_addr     <= r.addr;
    issue_wdata    <= (r.kind == STORE) ? r.data : ~r.data;  // unused field gets noise
    issue_result   <= (r.kind == ALU) ? r.data : ~r.data;
    @(posedge clk);
    issue <= 1'b0;
  endtask

  task automatic check_entry(row_t r);
    @(negedge clk);
    check_flag(busy, 1'b1, "busy after issue");
    check_state(u_backend_top.state, entry_state(r.kind), "state after issue");
  endtask

  task automatic wait_retire();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TMO) abort_run($sformatf("timeout: no retire within %0d cycles", TMO));
    end while (retire !== 1'b1);
  endtask

  task automatic check_reg(logic [4:0] rd);
    @(posedge clk);
    dbg_rs <= rd;
    @(negedge clk);
    check_word(dbg_rdata, mdl_regs[rd], $sformatf("x%0d", rd));
  endtask

  // an ignored issue leaves the back end idle
  task automatic expect_quiet(int cycles, string what);
    repeat (cycles) begin
      @(negedge clk);
      check_flag(retire, 1'b0, {"retire after ", what});
      check_flag(busy, 1'b0, {"busy after ", what});
    end
  endtask

  task automatic run_retire(row_t r);
    wait_retire();
    check_word(retire_pc, r.pc, "retire_pc");
    model_apply(r);
    check_reg(r.rd);
    accepted++;
  endtask

  initial begin
    row_t r;
    int   i;
    logic shadow;
    void'($urandom(32'h1098afcc));
    rst            = 1'b1;
    issue          = 1'b0;
    issue_pc       = '0;
    issue_kind     = ALU;
    issue_size     = DWORD;
    issue_unsigned = 1'b0;
    issue_rd       = '0;
    issue_addr     = '0;
    issue_wdata    = '0;
    issue_result   = '0;
    dbg_rs         = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    @(negedge clk);
    check_flag(busy, 1'b0, "busy after reset");
    check_flag(retire, 1'b0, "retire after reset");
    check_count(instret, 64'd0, "instret after reset");
    check_state(u_backend_top.state, IDLE, "state after reset");
    for (int k = 0; k < 32; k++) check_reg(5'(k));

    i = 0;
    while (i < NROWS) begin
      drive_issue(tbl[i]);
      if (tbl[i].mode == BUBBLE) begin
        expect_quiet(`MEM_LAT + 8, "reset pc issue");
        check_reg(tbl[i].rd);
        i++;
      end else begin
        shadow = (i + 1 < NROWS) && (tbl[i+1].mode == SHADOW);
        check_entry(tbl[i]);
        if (shadow) drive_issue(tbl[i+1]);  // lands while busy
        run_retire(tbl[i]);
        if (shadow) begin
          expect_quiet(`MEM_LAT + 8, "issue while busy");
          check_reg(tbl[i+1].rd);
          i += 2;
        end else begin
          i++;
        end
      end
    end

    for (int n = 0; n < NRAND; n++) begin
      r = random_op(n);
      drive_issue(r);
      check_entry(r);
      run_retire(r);
    end

    check_count(instret, 64'(accepted), "instret");
    check_state(u_backend_top.state, IDLE, "final state");
    if (u_backend_top.u_checker.fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("protocol checker saw %0d assertion failures", u_backend_top.u_checker.fail_count);
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+verilog
verilog/core_pkg.sv
verilog/mem_pkg.sv
verilog/dmem_if.sv
verilog/inst_seq.sv
verilog/lsu.sv
verilog/data_mem.sv
verilog/reg_file.sv
verilog/commit_unit.sv
verilog/backend_top.sv
dv/backend_checker.sv
dv/backend_tb.sv
